//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mini_core
RTL_TOP   ?= mini_core
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_TEXT := Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb.f
verilog/core_pkg.sv
verilog/bus_arbiter.sv
verilog/fetch_unit.sv
verilog/regfile.sv
verilog/hilo_unit.sv
verilog/exec_unit.sv
verilog/mini_core.sv
tb/tb_clock.sv
tb/tb_mini_core.sv

//--- tb/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic o_clk
);

    // free running, starts low
    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) o_clk = ~o_clk;
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_mini_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mini_core;
    import core_pkg::*;

    localparam word_t RESET_PC       = 32'h0000_0000;
    localparam word_t SKIP_PC        = 32'h0000_0044;
    localparam word_t END_PC         = 32'h0000_005c;
    localparam int    TIMEOUT_CYCLES = 2000;

    logic      clk;
    logic      reset;
    mem_req_t  mem_req;
    mem_resp_t mem_resp = '0;
    commit_t   dut_commit;

    word_t     mem_words [64];
    logic      mem_busy;
    int        wait_left;
    int        ack_delay;
    int        wait_cycles;
    int        commits_seen = 0;
    logic      reset_seen = 1'b0;
    logic      first_req_seen = 1'b0;
    logic      hold_pending = 1'b0;
    mem_req_t  held_req;

    // reference model state and expected traffic
    word_t     model_regs [32];
    word_t     model_mem [64];
    word_t     model_hi;
    word_t     model_lo;
    word_t     exp_pc_q [$];
    reg_addr_t exp_dest_q [$];
    word_t     exp_value_q [$];
    word_t     store_addr_q [$];
    word_t     store_data_q [$];

    tb_clock #(
        .PERIOD_NS (100)
    ) u_clock (
        .o_clk (clk)
    );

    mini_core #(
        .RESET_PC (RESET_PC)
    ) i_dut (
        .clk        (clk),
        .reset      (reset),
        .o_mem_req  (mem_req),
        .i_mem_resp (mem_resp),
        .o_commit   (dut_commit)
    );

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic word_t r_type(input logic [5:0] opc, input reg_addr_t rs,
                                     input reg_addr_t rt, input reg_addr_t rd,
                                     input logic [5:0] fn);
        return {opc, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t i_type(input logic [5:0] opc, input reg_addr_t rs,
                                     input reg_addr_t rt, input logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    task automatic load_program();
        for (int i = 0; i < 64; i++) begin
            mem_words[i] = 32'hfe00_0000 | (32'(i) << 2);
        end
        mem_words[0]  = i_type(6'h09, 5'd0, 5'd1, 16'd5);
        mem_words[1]  = i_type(6'h09, 5'd0, 5'd2, 16'hfffd);
        mem_words[2]  = r_type(6'h00, 5'd1, 5'd2, 5'd3, 6'h21);
        mem_words[3]  = r_type(6'h00, 5'd2, 5'd1, 5'd4, 6'h23);
        mem_words[4]  = i_type(6'h09, 5'd0, 5'd5, 16'h0080);
        mem_words[5]  = i_type(6'h2b, 5'd5, 5'd4, 16'd4);
        mem_words[6]  = i_type(6'h23, 5'd5, 5'd6, 16'd4);
        mem_words[7]  = i_type(6'h23, 5'd5, 5'd8, 16'd0);
        mem_words[8]  = i_type(6'h23, 5'd5, 5'd9, 16'd8);
        mem_words[9]  = r_type(6'h00, 5'd8, 5'd9, 5'd0, 6'h18);
        mem_words[10] = r_type(6'h1c, 5'd1, 5'd2, 5'd0, 6'h00);
        mem_words[11] = r_type(6'h1c, 5'd8, 5'd8, 5'd0, 6'h04);
        mem_words[12] = r_type(6'h00, 5'd0, 5'd0, 5'd10, 6'h10);
        mem_words[13] = r_type(6'h00, 5'd0, 5'd0, 5'd11, 6'h12);
        // not taken, then taken over word 17
        mem_words[14] = i_type(6'h04, 5'd3, 5'd1, 16'd1);
        mem_words[15] = i_type(6'h09, 5'd0, 5'd12, 16'd7);
        mem_words[16] = i_type(6'h04, 5'd6, 5'd4, 16'd1);
        mem_words[17] = i_type(6'h09, 5'd0, 5'd13, 16'h0099);
        // branch target writes a register
        mem_words[18] = i_type(6'h09, 5'd0, 5'd7, 16'h0042);
        mem_words[19] = r_type(6'h00, 5'd1, 5'd0, 5'd0, 6'h11);
        mem_words[20] = r_type(6'h00, 5'd2, 5'd0, 5'd0, 6'h13);
        mem_words[21] = r_type(6'h00, 5'd0, 5'd0, 5'd14, 6'h10);
        mem_words[22] = r_type(6'h00, 5'd0, 5'd0, 5'd15, 6'h12);
        // park the core in a self loop
        mem_words[23] = i_type(6'h04, 5'd0, 5'd0, 16'hffff);
        mem_words[32] = 32'h1234_5678;
        mem_words[34] = 32'h9abc_def0;
    endtask

    task automatic expect_write(input word_t pc, input reg_addr_t dest, input word_t value);
        if (dest != 5'd0) begin
            model_regs[dest] = value;
            exp_pc_q.push_back(pc);
            exp_dest_q.push_back(dest);
            exp_value_q.push_back(value);
        end
    endtask

    // plain ISA interpreter, one instruction per step
    task automatic run_reference();
        word_t       pc;
        word_t       next_pc;
        word_t       w;
        word_t       a;
        word_t       b;
        word_t       simm;
        word_t       addr;
        logic [63:0] prod;
        logic [63:0] acc;
        logic [5:0]  opc;
        logic [5:0]  fn;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            model_mem[i] = mem_words[i];
        end
        model_hi = '0;
        model_lo = '0;
        pc = RESET_PC;
        steps = 0;
        while (pc != END_PC && steps < 200) begin
            w = model_mem[pc[7:2]];
            opc = w[31:26];
            fn = w[5:0];
            a = model_regs[w[25:21]];
            b = model_regs[w[20:16]];
            simm = {{16{w[15]}}, w[15:0]};
            addr = a + simm;
            prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
            acc = {model_hi, model_lo};
            next_pc = pc + 32'd4;
            case (opc)
                6'h00: begin
                    case (fn)
                        6'h21: expect_write(pc, w[15:11], a + b);
                        6'h23: expect_write(pc, w[15:11], a - b);
                        6'h18: acc = prod;
                        6'h10: expect_write(pc, w[15:11], model_hi);
                        6'h12: expect_write(pc, w[15:11], model_lo);
                        6'h11: acc[63:32] = a;
                        6'h13: acc[31:0] = a;
                        default: begin
                        end
                    endcase
                end
                6'h1c: begin
                    if (fn == 6'h00) begin
                        acc = acc + prod;
                    end else if (fn == 6'h04) begin
                        acc = acc - prod;
                    end
                end
                6'h09: expect_write(pc, w[20:16], addr);
                6'h23: expect_write(pc, w[20:16], model_mem[addr[7:2]]);
                6'h2b: begin
                    model_mem[addr[7:2]] = b;
                    store_addr_q.push_back(addr);
                    store_data_q.push_back(b);
                end
                6'h04: begin
                    if (a == b) begin
                        next_pc = pc + 32'd4 + (simm << 2);
                    end
                end
                default: begin
                end
            endcase
            {model_hi, model_lo} = acc;
            pc = next_pc;
            steps++;
        end
    endtask

    task automatic check_store(input word_t addr, input word_t data);
        if (store_addr_q.size() == 0) begin
            $display("write request at 0x%08h that the program never makes", addr);
            abort_run();
        end else begin
            check_word("o_mem_req.addr", addr, store_addr_q.pop_front());
            check_word("o_mem_req.wdata", data, store_data_q.pop_front());
        end
    endtask

    task automatic serve_request();
        if (mem_req.addr[31:8] != '0) begin
            $display("bus access at 0x%08h is outside the 64-word memory", mem_req.addr);
            abort_run();
        end else begin
            if (mem_req.we) begin
                check_store(mem_req.addr, mem_req.wdata);
                mem_words[mem_req.addr[7:2]] <= mem_req.wdata;
            end
            mem_resp.rdata <= mem_words[mem_req.addr[7:2]];
            mem_resp.ack   <= 1'b1;
        end
    endtask

    // memory with 1 to 4 cycles of ack latency
    always @(posedge clk) begin
        if (reset) begin
            mem_resp  <= '0;
            mem_busy  <= 1'b0;
            wait_left <= 0;
        end else if (mem_resp.ack) begin
            mem_resp.ack <= 1'b0;
        end else if (mem_busy) begin
            if (wait_left == 0) begin
                serve_request();
                mem_busy <= 1'b0;
            end else begin
                wait_left <= wait_left - 1;
            end
        end else if (mem_req.valid) begin
            ack_delay = int'($urandom % 4) + 1;
            if (ack_delay == 1) begin
                serve_request();
            end else begin
                mem_busy  <= 1'b1;
                wait_left <= ack_delay - 2;
            end
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            reset_seen <= 1'b1;
        end else if (mem_req.valid) begin
            first_req_seen <= 1'b1;
        end
    end

    // a pending request must not move until its ack
    always @(posedge clk) begin
        if (hold_pending) begin
            assert (mem_req === held_req) else begin
                $display("MISMATCH o_mem_req: got 0x%h expected 0x%h", mem_req, held_req);
                abort_run();
            end
        end
        hold_pending <= !reset && mem_req.valid && !mem_resp.ack;
        held_req     <= mem_req;
    end

    always @(posedge clk) begin
        if (!reset && dut_commit.valid) begin
            if (commits_seen >= exp_pc_q.size()) begin
                $display("commit at pc 0x%08h past the end of the program", dut_commit.pc);
                abort_run();
            end else begin
                check_word("o_commit.pc", dut_commit.pc, exp_pc_q[commits_seen]);
                check_word("o_commit.dest", {27'd0, dut_commit.dest},
                           {27'd0, exp_dest_q[commits_seen]});
                check_word("o_commit.value", dut_commit.value, exp_value_q[commits_seen]);
                commits_seen <= commits_seen + 1;
            end
        end
    end

    quiet_in_reset: assert property (@(posedge clk)
        (reset && reset_seen) |-> (!mem_req.valid && !dut_commit.valid))
    else begin
        $display("MISMATCH o_mem_req.valid 0x%h o_commit.valid 0x%h in reset, expected 0x0",
                 $sampled(mem_req.valid), $sampled(dut_commit.valid));
        abort_run();
    end

    first_fetch_at_reset_pc: assert property (@(posedge clk)
        (!reset && mem_req.valid && !first_req_seen) |->
        (mem_req.addr == RESET_PC && !mem_req.we))
    else begin
        $display("MISMATCH o_mem_req.addr: got 0x%08h expected 0x%08h",
                 $sampled(mem_req.addr), RESET_PC);
        abort_run();
    end

    skipped_never_commits: assert property (@(posedge clk) disable iff (reset)
        dut_commit.valid |-> (dut_commit.pc != SKIP_PC))
    else begin
        $display("MISMATCH o_commit.pc: got 0x%08h from the skipped slot",
                 $sampled(dut_commit.pc));
        abort_run();
    end

    initial begin
        void'($urandom(32'h3420_cad2));
        reset = 1'b1;
        load_program();
        run_reference();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        wait_cycles = 0;
        while (commits_seen < exp_pc_q.size() && wait_cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (commits_seen < exp_pc_q.size()) begin
            $display("timeout after %0d cycles with %0d of %0d commits seen",
                     wait_cycles, commits_seen, exp_pc_q.size());
            abort_run();
        end else if (store_addr_q.size() != 0) begin
            $display("store never reached the memory bus");
            abort_run();
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- verilog/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    input  logic                clk,
    input  logic                reset,
    input  core_pkg::mem_req_t  i_fetch_req,
    input  core_pkg::mem_req_t  i_data_req,
    output core_pkg::mem_resp_t o_fetch_resp,
    output core_pkg::mem_resp_t o_data_resp,
    output core_pkg::mem_req_t  o_mem_req,
    input  core_pkg::mem_resp_t i_mem_resp
);
    import core_pkg::*;

    typedef enum logic [1:0] {
        OWN_IDLE,
        OWN_FETCH,
        OWN_DATA
    } owner_t;

    owner_t owner;
    owner_t grant;

    // new grant only from idle, data side first
    always_comb begin
        grant = owner;
        if (owner == OWN_IDLE) begin
            if (i_data_req.valid) begin
                grant = OWN_DATA;
            end else if (i_fetch_req.valid) begin
                grant = OWN_FETCH;
            end
        end
    end

    always_comb begin
        case (grant)
            OWN_DATA:  o_mem_req = i_data_req;
            OWN_FETCH: o_mem_req = i_fetch_req;
            default:   o_mem_req = '0;
        endcase
    end

    // ack only goes back to the owner of the bus
    assign o_fetch_resp.ack   = i_mem_resp.ack && (grant == OWN_FETCH);
    assign o_fetch_resp.rdata = i_mem_resp.rdata;
    assign o_data_resp.ack    = i_mem_resp.ack && (grant == OWN_DATA);
    assign o_data_resp.rdata  = i_mem_resp.rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            owner <= OWN_IDLE;
        end else if (i_mem_resp.ack) begin
            owner <= OWN_IDLE;
        end else begin
            owner <= grant;
        end
    end

endmodule

`default_nettype wire

//--- verilog/core_pkg.sv
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // instruction field widths
    localparam int OPCODE_W = 6;
    localparam int FUNCT_W  = 6;
    localparam int IMM_W    = 16;

    typedef struct packed {
        logic [OPCODE_W-1:0] opcode;
        reg_addr_t           rs;
        reg_addr_t           rt;
        reg_addr_t           rd;
        logic [4:0]          shamt;
        logic [FUNCT_W-1:0]  funct;
    } inst_fields_t;

    // primary opcodes
    localparam logic [OPCODE_W-1:0] OPC_SPECIAL  = 6'h00;
    localparam logic [OPCODE_W-1:0] OPC_SPECIAL2 = 6'h1c;
    localparam logic [OPCODE_W-1:0] OPC_ADDIU    = 6'h09;
    localparam logic [OPCODE_W-1:0] OPC_BEQ      = 6'h04;
    localparam logic [OPCODE_W-1:0] OPC_LW       = 6'h23;
    localparam logic [OPCODE_W-1:0] OPC_SW       = 6'h2b;

    // function codes, SPECIAL and SPECIAL2
    localparam logic [FUNCT_W-1:0] FN_ADDU = 6'h21;
    localparam logic [FUNCT_W-1:0] FN_SUBU = 6'h23;
    localparam logic [FUNCT_W-1:0] FN_MULT = 6'h18;
    localparam logic [FUNCT_W-1:0] FN_MFHI = 6'h10;
    localparam logic [FUNCT_W-1:0] FN_MTHI = 6'h11;
    localparam logic [FUNCT_W-1:0] FN_MFLO = 6'h12;
    localparam logic [FUNCT_W-1:0] FN_MTLO = 6'h13;
    localparam logic [FUNCT_W-1:0] FN_MADD = 6'h00;
    localparam logic [FUNCT_W-1:0] FN_MSUB = 6'h04;

    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADDU,
        OP_SUBU,
        OP_ADDIU,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_MULT,
        OP_MADD,
        OP_MSUB,
        OP_MFHI,
        OP_MFLO,
        OP_MTHI,
        OP_MTLO
    } op_t;

    typedef struct packed {
        logic  valid;
        logic  we;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  ack;
        word_t rdata;
    } mem_resp_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t dest;
        word_t     value;
    } commit_t;

endpackage

`default_nettype wire

//--- verilog/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                i_inst_valid,
    input  core_pkg::word_t     i_inst,
    input  core_pkg::word_t     i_inst_pc,
    output logic                o_inst_take,
    output logic                o_redirect,
    output core_pkg::word_t     o_redirect_pc,
    output core_pkg::mem_req_t  o_req,
    input  core_pkg::mem_resp_t i_resp,
    output core_pkg::reg_addr_t o_ra1,
    output core_pkg::reg_addr_t o_ra2,
    output logic                o_rf_we,
    output core_pkg::reg_addr_t o_rf_wa,
    output core_pkg::word_t     o_rf_wd,
    input  core_pkg::word_t     i_rd1,
    input  core_pkg::word_t     i_rd2,
    output logic                o_hilo_valid,
    output core_pkg::op_t       o_hilo_op,
    output core_pkg::word_t     o_hilo_a,
    output core_pkg::word_t     o_hilo_b,
    input  core_pkg::word_t     i_hi,
    input  core_pkg::word_t     i_lo,
    output core_pkg::commit_t   o_commit
);
    import core_pkg::*;

    typedef enum logic [1:0] {
        ST_READY,
        ST_EXEC,
        ST_MEM
    } state_t;

    state_t       state;
    op_t          op;
    op_t          take_op;
    word_t        inst;
    word_t        pc;
    word_t        load_data;
    inst_fields_t f;
    word_t        imm_sext;
    logic         active;
    logic         wb_en;
    reg_addr_t    wb_addr;
    word_t        wb_data;
    logic         hilo_en;

    function automatic op_t decode(input word_t w);
        inst_fields_t d;
        op_t          r;
        d = w;
        r = OP_NOP;
        case (d.opcode)
            OPC_SPECIAL: begin
                case (d.funct)
                    FN_ADDU: r = OP_ADDU;
                    FN_SUBU: r = OP_SUBU;
                    FN_MULT: r = OP_MULT;
                    FN_MFHI: r = OP_MFHI;
                    FN_MFLO: r = OP_MFLO;
                    FN_MTHI: r = OP_MTHI;
                    FN_MTLO: r = OP_MTLO;
                    default: r = OP_NOP;
                endcase
            end
            OPC_SPECIAL2: begin
                case (d.funct)
                    FN_MADD: r = OP_MADD;
                    FN_MSUB: r = OP_MSUB;
                    default: r = OP_NOP;
                endcase
            end
            OPC_ADDIU: r = OP_ADDIU;
            OPC_LW:    r = OP_LW;
            OPC_SW:    r = OP_SW;
            OPC_BEQ:   r = OP_BEQ;
            default:   r = OP_NOP;
        endcase
        return r;
    endfunction

    assign take_op     = decode(i_inst);
    assign o_inst_take = (state == ST_READY) && i_inst_valid;

    assign f        = inst;
    assign imm_sext = {{(32 - IMM_W){inst[IMM_W-1]}}, inst[IMM_W-1:0]};
    assign active   = (state == ST_EXEC);
    assign o_ra1    = f.rs;
    assign o_ra2    = f.rt;

    always_comb begin
        wb_en   = 1'b0;
        wb_addr = f.rd;
        wb_data = i_rd1 + i_rd2;
        hilo_en = 1'b0;
        case (op)
            OP_ADDU: wb_en = 1'b1;
            OP_SUBU: begin
                wb_en   = 1'b1;
                wb_data = i_rd1 - i_rd2;
            end
            OP_ADDIU: begin
                wb_en   = 1'b1;
                wb_addr = f.rt;
                wb_data = i_rd1 + imm_sext;
            end
            OP_LW: begin
                wb_en   = 1'b1;
                wb_addr = f.rt;
                wb_data = load_data;
            end
            OP_MFHI: begin
                wb_en   = 1'b1;
                wb_data = i_hi;
            end
            OP_MFLO: begin
                wb_en   = 1'b1;
                wb_data = i_lo;
            end
            OP_MULT, OP_MADD, OP_MSUB, OP_MTHI, OP_MTLO: hilo_en = 1'b1;
            default: wb_en = 1'b0;
        endcase
    end

    // writes to r0 are dropped, so they never show up as commits
    assign o_rf_we        = active && wb_en && (wb_addr != '0);
    assign o_rf_wa        = wb_addr;
    assign o_rf_wd        = wb_data;
    assign o_commit.valid = o_rf_we;
    assign o_commit.pc    = pc;
    assign o_commit.dest  = wb_addr;
    assign o_commit.value = wb_data;

    assign o_hilo_valid = active && hilo_en;
    assign o_hilo_op    = op;
    assign o_hilo_a     = i_rd1;
    assign o_hilo_b     = i_rd2;

    // branch target is relative to the next pc
    assign o_redirect    = active && (op == OP_BEQ) && (i_rd1 == i_rd2);
    assign o_redirect_pc = pc + 32'd4 + {imm_sext[29:0], 2'b00};

    // operands stay put while waiting, so the request is stable
    assign o_req.valid = (state == ST_MEM);
    assign o_req.we    = (op == OP_SW);
    assign o_req.addr  = i_rd1 + imm_sext;
    assign o_req.wdata = i_rd2;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_READY;
        end else begin
            case (state)
                ST_READY: begin
                    if (o_inst_take) begin
                        if (take_op == OP_LW || take_op == OP_SW) begin
                            state <= ST_MEM;
                        end else begin
                            state <= ST_EXEC;
                        end
                    end
                end
                // finish the load/store one cycle after ack
                ST_MEM: begin
                    if (i_resp.ack) begin
                        state <= ST_EXEC;
                    end
                end
                default: state <= ST_READY;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (o_inst_take) begin
            inst <= i_inst;
            pc   <= i_inst_pc;
            op   <= take_op;
        end
        if (state == ST_MEM && i_resp.ack) begin
            load_data <= i_resp.rdata;
        end
    end

endmodule

`default_nettype wire

//--- verilog/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter core_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic                clk,
    input  logic                reset,
    output core_pkg::mem_req_t  o_req,
    input  core_pkg::mem_resp_t i_resp,
    output logic                o_inst_valid,
    output core_pkg::word_t     o_inst,
    output core_pkg::word_t     o_inst_pc,
    input  logic                i_inst_take,
    input  logic                i_redirect,
    input  core_pkg::word_t     i_redirect_pc
);
    import core_pkg::*;

    logic  req_valid;
    word_t req_addr;
    word_t pc;
    word_t pc_nxt;
    logic  discard;
    logic  buf_valid;
    word_t buf_inst;
    word_t buf_pc;
    logic  ack;
    logic  fill;
    logic  buf_free_nxt;
    logic  issue;

    assign ack  = req_valid && i_resp.ack;
    // response of a flushed fetch never reaches the buffer
    assign fill = ack && !discard && !i_redirect;

    // buffer empty after this edge
    assign buf_free_nxt = i_redirect || (!fill && (!buf_valid || i_inst_take));
    assign issue        = (!req_valid || ack) && buf_free_nxt;

    always_comb begin
        pc_nxt = pc;
        if (i_redirect) begin
            pc_nxt = i_redirect_pc;
        end else if (fill) begin
            pc_nxt = req_addr + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc        <= RESET_PC;
            req_valid <= 1'b0;
            discard   <= 1'b0;
            buf_valid <= 1'b0;
        end else begin
            pc        <= pc_nxt;
            buf_valid <= !buf_free_nxt;
            if (issue) begin
                req_valid <= 1'b1;
            end else if (ack) begin
                req_valid <= 1'b0;
            end
            // fetch still in flight when the branch resolved
            if (i_redirect && req_valid && !ack) begin
                discard <= 1'b1;
            end else if (ack) begin
                discard <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            req_addr <= pc_nxt;
        end
        if (fill) begin
            buf_inst <= i_resp.rdata;
            buf_pc   <= req_addr;
        end
    end

    assign o_req.valid = req_valid;
    assign o_req.we    = 1'b0;
    assign o_req.addr  = req_addr;
    assign o_req.wdata = '0;

    assign o_inst_valid = buf_valid;
    assign o_inst       = buf_inst;
    assign o_inst_pc    = buf_pc;

endmodule

`default_nettype wire

//--- verilog/hilo_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hilo_unit (
    input  logic            clk,
    input  logic            reset,
    input  core_pkg::op_t   i_op,
    input  logic            i_valid,
    input  core_pkg::word_t i_a,
    input  core_pkg::word_t i_b,
    output core_pkg::word_t o_hi,
    output core_pkg::word_t o_lo
);
    import core_pkg::*;

    word_t              hi;
    word_t              lo;
    logic signed [63:0] product;
    logic        [63:0] acc;

    // both operands sign extended to 64 bits
    assign product = $signed(i_a) * $signed(i_b);

    always_comb begin
        case (i_op)
            OP_MADD: acc = {hi, lo} + product;
            OP_MSUB: acc = {hi, lo} - product;
            default: acc = product;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (i_valid) begin
            case (i_op)
                OP_MTHI: hi <= i_a;
                OP_MTLO: lo <= i_a;
                OP_MULT, OP_MADD, OP_MSUB: begin
                    hi <= acc[63:32];
                    lo <= acc[31:0];
                end
                default: begin
                end
            endcase
        end
    end

    assign o_hi = hi;
    assign o_lo = lo;

endmodule

`default_nettype wire

//--- verilog/mini_core.sv
`timescale 1ns/1ps
`default_nettype none

module mini_core #(
    parameter core_pkg::word_t RESET_PC = 32'hbfc0_0000
) (
    input  logic                clk,
    input  logic                reset,
    output core_pkg::mem_req_t  o_mem_req,
    input  core_pkg::mem_resp_t i_mem_resp,
    output core_pkg::commit_t   o_commit
);
    import core_pkg::*;

    mem_req_t  fetch_req;
    mem_req_t  data_req;
    mem_resp_t fetch_resp;
    mem_resp_t data_resp;
    logic      inst_valid;
    word_t     inst;
    word_t     inst_pc;
    logic      inst_take;
    logic      redirect;
    word_t     redirect_pc;
    reg_addr_t ra1;
    reg_addr_t ra2;
    word_t     rd1;
    word_t     rd2;
    logic      rf_we;
    reg_addr_t rf_wa;
    word_t     rf_wd;
    logic      hilo_valid;
    op_t       hilo_op;
    word_t     hilo_a;
    word_t     hilo_b;
    word_t     hi;
    word_t     lo;

    bus_arbiter u_arbiter (
        .clk          (clk),
        .reset        (reset),
        .i_fetch_req  (fetch_req),
        .i_data_req   (data_req),
        .o_fetch_resp (fetch_resp),
        .o_data_resp  (data_resp),
        .o_mem_req    (o_mem_req),
        .i_mem_resp   (i_mem_resp)
    );

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk           (clk),
        .reset         (reset),
        .o_req         (fetch_req),
        .i_resp        (fetch_resp),
        .o_inst_valid  (inst_valid),
        .o_inst        (inst),
        .o_inst_pc     (inst_pc),
        .i_inst_take   (inst_take),
        .i_redirect    (redirect),
        .i_redirect_pc (redirect_pc)
    );

    regfile u_regfile (
        .clk   (clk),
        .reset (reset),
        .i_ra1 (ra1),
        .i_ra2 (ra2),
        .o_rd1 (rd1),
        .o_rd2 (rd2),
        .i_we  (rf_we),
        .i_wa  (rf_wa),
        .i_wd  (rf_wd)
    );

    hilo_unit u_hilo (
        .clk     (clk),
        .reset   (reset),
        .i_op    (hilo_op),
        .i_valid (hilo_valid),
        .i_a     (hilo_a),
        .i_b     (hilo_b),
        .o_hi    (hi),
        .o_lo    (lo)
    );

    exec_unit u_exec (
        .clk           (clk),
        .reset         (reset),
        .i_inst_valid  (inst_valid),
        .i_inst        (inst),
        .i_inst_pc     (inst_pc),
        .o_inst_take   (inst_take),
        .o_redirect    (redirect),
        .o_redirect_pc (redirect_pc),
        .o_req         (data_req),
        .i_resp        (data_resp),
        .o_ra1         (ra1),
        .o_ra2         (ra2),
        .o_rf_we       (rf_we),
        .o_rf_wa       (rf_wa),
        .o_rf_wd       (rf_wd),
        .i_rd1         (rd1),
        .i_rd2         (rd2),
        .o_hilo_valid  (hilo_valid),
        .o_hilo_op     (hilo_op),
        .o_hilo_a      (hilo_a),
        .o_hilo_b      (hilo_b),
        .i_hi          (hi),
        .i_lo          (lo),
        .o_commit      (o_commit)
    );

endmodule

`default_nettype wire

//--- verilog/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                clk,
    input  logic                reset,
    input  core_pkg::reg_addr_t i_ra1,
    input  core_pkg::reg_addr_t i_ra2,
    output core_pkg::word_t     o_rd1,
    output core_pkg::word_t     o_rd2,
    input  logic                i_we,
    input  core_pkg::reg_addr_t i_wa,
    input  core_pkg::word_t     i_wd
);
    import core_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_wa != '0)) begin
            regs[i_wa] <= i_wd;
        end
    end

    // r0 is hardwired
    assign o_rd1 = (i_ra1 == '0) ? '0 : regs[i_ra1];
    assign o_rd2 = (i_ra2 == '0) ? '0 : regs[i_ra2];

endmodule

`default_nettype wire
